// File: testbench/controlUnitPatterns.txt
# word(hex) overflow cycles regWrite memWrite epcWrite break
# On a break line the cycles column is the number of cycles held in stBreak
00221820 0 7 1 0 0 0
00221822 0 7 1 0 0 0
00221824 0 7 1 0 0 0
20220005 0 7 1 0 0 0
24220005 0 7 1 0 0 0
10220004 0 6 0 0 0 0
14220004 0 6 0 0 0 0
8c220008 0 8 1 0 0 0
ac220008 0 7 0 1 0 0
08000100 0 5 0 0 0 0
0c000100 0 6 1 0 0 0
03e00008 0 5 0 0 0 0
00000000 0 4 0 0 0 0
00221820 1 9 0 0 1 0
00221822 1 9 0 0 1 0
20220005 1 9 0 0 1 0
24220005 1 7 1 0 0 0
fc000000 0 7 0 0 1 0
00221801 0 7 0 0 1 0
00021080 0 7 0 0 1 0
0000000d 0 20 0 0 0 1

// File: compile.f
rtl/ctrlPkg.sv
rtl/instrRegister.sv
rtl/opDecoder.sv
rtl/stateSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
testbench/controlUnit_props.sv
testbench/controlUnitTb.sv

// File: testbench/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb;

	localparam string patternFile = "testbench/controlUnitPatterns.txt";

	typedef struct packed {
		logic [31:0] word;
		logic ovf;
		logic [7:0] cycles;
		logic [3:0] regWrites;
		logic [3:0] memWrites;
		logic [3:0] epcWrites;
		logic isBreak;
	} patternT;

	logic Clk;
	logic Reset;
	logic [ctrlPkg::wordW-1:0] memData;
	logic overflow;
	ctrlPkg::ctrlWordT ctrl;
	ctrlPkg::stateT state;

	patternT patterns[$];
	int cycleCount;
	int cycleLimit;
	logic [31:0] lcgState;

	controlUnit controlUnit_i (
		.Clk(Clk),
		.Reset(Reset),
		.memData(memData),
		.overflow(overflow),
		.ctrl(ctrl),
		.state(state)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			abortRun($sformatf("[ERROR] %0t %s actual=%0h expected=%0h",
				$time, name, actual, expected));
		end
	endtask

	// Watchdog on the whole run
	initial begin
		cycleCount = 0;
		forever begin
			@(posedge Clk);
			cycleCount++;
			if (controlUnit_i.controlUnitProps_i.violationCount != 0) begin
				abortRun("A control word property failed");
			end
			if (cycleLimit != 0 && cycleCount > cycleLimit) begin
				abortRun($sformatf("Timeout: no result after %0d clock cycles", cycleCount));
			end
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] seed);
		return seed * 32'd1664525 + 32'd1013904223;
	endfunction

	// One for each jump, two PC loads per exception
	function automatic int expectedPcWrites(input logic [31:0] word, input int epcWrites);
		logic [5:0] opcode;
		logic [5:0] funct;
		int jumps;
		opcode = word[31:26];
		funct = word[5:0];
		jumps = 0;
		if (opcode == ctrlPkg::opJ || opcode == ctrlPkg::opJal) begin
			jumps = 1;
		end
		if (opcode == ctrlPkg::opRType && funct == ctrlPkg::fnJr) begin
			jumps = 1;
		end
		return jumps + 2 * epcWrites;
	endfunction

	function automatic logic [9:0] strobeBits(input ctrlPkg::ctrlWordT word);
		return {word.pcWrite, word.pcWriteCond, word.irWrite, word.aWrite, word.bWrite,
			word.aluOutWrite, word.mdrWrite, word.epcWrite, word.regWrite, word.memWrite};
	endfunction

	// Memory answers only in the wait state, noise otherwise
	task automatic stepCycle(input logic [31:0] word);
		@(posedge Clk);
		#1;
		if (state == ctrlPkg::stFetchWait) begin
			memData = word;
		end else begin
			lcgState = nextRandom(lcgState);
			memData = lcgState;
		end
	endtask

	task automatic readPatterns();
		int fd;
		int fields;
		int ovf, cycles, regW, memW, epcW, brk;
		logic [31:0] word;
		string line;
		patternT entry;
		fd = $fopen(patternFile, "r");
		if (fd == 0) begin
			abortRun("Cannot open the pattern file testbench/controlUnitPatterns.txt");
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0) begin
				break;
			end
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			fields = $sscanf(line, "%h %d %d %d %d %d %d", word, ovf, cycles, regW, memW,
				epcW, brk);
			if (fields != 7) begin
				abortRun($sformatf("Pattern line is not in the expected format: %s", line));
			end
			entry = {word, ovf[0], cycles[7:0], regW[3:0], memW[3:0], epcW[3:0], brk[0]};
			patterns.push_back(entry);
		end
		$fclose(fd);
	endtask

	task automatic applyReset();
		ctrlPkg::ctrlWordT expected;
		expected = '0;
		expected.regDst = ctrlPkg::dstRa; // Link register cleared in reset
		expected.regWrite = 1'b1;
		Reset = 1'b1;
		repeat (8) @(posedge Clk);
		#1;
		checkValue("state in reset", state, ctrlPkg::stReset);
		checkValue("ctrl in reset", ctrl, expected);
		Reset = 1'b0;
		stepCycle('0);
		checkValue("state after reset", state, ctrlPkg::stIdle);
		checkValue("ctrl after reset", ctrl, '0);
	endtask

	task automatic holdBreak(input patternT pat, input string tag);
		repeat (pat.cycles) begin
			stepCycle(pat.word);
			checkValue({tag, " state in break"}, state, ctrlPkg::stBreak);
			checkValue({tag, " strobes in break"}, strobeBits(ctrl), '0);
		end
	endtask

	task automatic runPattern(input patternT pat, input int index);
		int cycles;
		int regWrites, memWrites, epcWrites, pcWrites, irWrites;
		string tag;
		ctrlPkg::pcSrcT excVector;
		ctrlPkg::branchT branchSense;
		tag = $sformatf("pattern %0d", index);
		overflow = pat.ovf; // Held for the whole instruction
		// Overflow traps go to their own vector, unknown opcodes to the other
		if (pat.ovf) begin
			excVector = ctrlPkg::pcOvfVector;
		end else begin
			excVector = ctrlPkg::pcOpcVector;
		end
		if (pat.word[31:26] == ctrlPkg::opBne) begin
			branchSense = ctrlPkg::brOnNotZero;
		end else begin
			branchSense = ctrlPkg::brOnZero;
		end
		cycles = 0;
		regWrites = 0;
		memWrites = 0;
		epcWrites = 0;
		pcWrites = 0;
		irWrites = 0;
		do begin
			cycles++;
			regWrites += ctrl.regWrite;
			memWrites += ctrl.memWrite;
			epcWrites += ctrl.epcWrite;
			pcWrites += ctrl.pcWrite;
			irWrites += ctrl.irWrite;
			if (state == ctrlPkg::stExc1 || state == ctrlPkg::stExc2 ||
				state == ctrlPkg::stExc3) begin
				checkValue({tag, " exception pcSrc"}, ctrl.pcSrc, excVector);
			end
			if (state == ctrlPkg::stBranch2) begin
				checkValue({tag, " branchOn"}, ctrl.branchOn, branchSense);
			end
			stepCycle(pat.word);
		end while (state != ctrlPkg::stIdle && state != ctrlPkg::stBreak);
		if (pat.isBreak) begin
			checkValue({tag, " state"}, state, ctrlPkg::stBreak);
			checkValue({tag, " cycles to break"}, cycles, 4);
			holdBreak(pat, tag);
			applyReset(); // Only reset leaves stBreak
		end else begin
			checkValue({tag, " end state"}, state, ctrlPkg::stIdle);
			checkValue({tag, " cycles"}, cycles, pat.cycles);
			checkValue({tag, " regWrite count"}, regWrites, pat.regWrites);
			checkValue({tag, " memWrite count"}, memWrites, pat.memWrites);
			checkValue({tag, " epcWrite count"}, epcWrites, pat.epcWrites);
			checkValue({tag, " pcWrite count"}, pcWrites,
				expectedPcWrites(pat.word, pat.epcWrites));
			checkValue({tag, " irWrite count"}, irWrites, 2);
		end
	endtask

	initial begin
		int cycleSum;
		Reset = 1'b1;
		memData = '0;
		overflow = 1'b0;
		lcgState = 32'hdac;
		cycleLimit = 0;
		readPatterns();
		cycleSum = 0;
		foreach (patterns[i]) begin
			cycleSum += patterns[i].cycles;
		end
		cycleLimit = cycleSum + 100;
		applyReset();
		foreach (patterns[i]) begin
			runPattern(patterns[i], i);
		end
		if (controlUnit_i.controlUnitProps_i.violationCount == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			abortRun($sformatf("Control word properties were violated %0d times",
				controlUnit_i.controlUnitProps_i.violationCount));
		end
	end

endmodule

// File: testbench/controlUnit_props.sv
`timescale 1ns/10ps

module controlUnit_props (
	input logic Clk,
	input logic Reset,
	input ctrlPkg::ctrlWordT ctrl,
	input ctrlPkg::stateT state
);

	int violationCount = 0; // Read by the testbench at the end

	noMemRegClash: assert property (@(posedge Clk) disable iff (Reset)
		!(ctrl.memWrite && ctrl.regWrite))
		else begin
			violationCount++;
			$error("memWrite and regWrite high in the same cycle");
		end

	epcOnlyInExc1: assert property (@(posedge Clk) disable iff (Reset)
		ctrl.epcWrite |-> (state == ctrlPkg::stExc1))
		else begin
			violationCount++;
			$error("epcWrite high outside stExc1");
		end

	// Instruction latch window
	irWriteInFetch: assert property (@(posedge Clk) disable iff (Reset)
		ctrl.irWrite |-> (state == ctrlPkg::stFetchWait || state == ctrlPkg::stDecode))
		else begin
			violationCount++;
			$error("irWrite high outside stFetchWait and stDecode");
		end

endmodule

bind controlUnit controlUnit_props controlUnitProps_i (
	.Clk(Clk),
	.Reset(Reset),
	.ctrl(ctrl),
	.state(state)
);

// File: rtl/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input logic Clk,
	input logic Reset,
	input logic [ctrlPkg::wordW-1:0] memData,
	input logic overflow,
	output ctrlPkg::ctrlWordT ctrl,
	output ctrlPkg::stateT state
);

	ctrlPkg::instrWordU instr;
	ctrlPkg::excCauseT cause;
	ctrlPkg::excCauseT excCauseNext;
	ctrlPkg::instrClassT instrClass;
	ctrlPkg::aluOpT aluOp;
	logic excEnter;
	logic isAddiu;

	instrRegister instrRegister_i (
		.Clk(Clk),
		.Reset(Reset),
		.state(state),
		.memData(memData),
		.excEnter(excEnter),
		.excCauseNext(excCauseNext),
		.instr(instr),
		.cause(cause)
	);

	opDecoder opDecoder_i (
		.instr(instr),
		.instrClass(instrClass),
		.aluOp(aluOp),
		.isAddiu(isAddiu)
	);

	stateSequencer stateSequencer_i (
		.Clk(Clk),
		.Reset(Reset),
		.instrClass(instrClass),
		.isAddiu(isAddiu),
		.overflow(overflow),
		.state(state),
		.excEnter(excEnter),
		.excCauseNext(excCauseNext)
	);

	controlWordGen controlWordGen_i (
		.state(state),
		.instrClass(instrClass),
		.aluOp(aluOp),
		.instr(instr),
		.cause(cause),
		.ctrl(ctrl)
	);

endmodule

// File: rtl/controlWordGen.sv
`timescale 1ns/10ps

module controlWordGen (
	input ctrlPkg::stateT state,
	input ctrlPkg::instrClassT instrClass,
	input ctrlPkg::aluOpT aluOp,
	input ctrlPkg::instrWordU instr,
	input ctrlPkg::excCauseT cause,
	output ctrlPkg::ctrlWordT ctrl
);

	ctrlPkg::branchT branchSense;
	ctrlPkg::pcSrcT excVector;
	logic isRType;

	assign isRType = (instrClass == ctrlPkg::clsArith);

	always_comb begin
		if (instr.iFields.opcode == ctrlPkg::opBne) begin
			branchSense = ctrlPkg::brOnNotZero;
		end else begin
			branchSense = ctrlPkg::brOnZero;
		end
	end

	always_comb begin
		if (cause == ctrlPkg::causeOverflow) begin
			excVector = ctrlPkg::pcOvfVector;
		end else begin
			excVector = ctrlPkg::pcOpcVector;
		end
	end

	always_comb begin
		ctrl = ctrlPkg::ctrlIdle;
		case (state)
			ctrlPkg::stReset: begin
				ctrl.regDst = ctrlPkg::dstRa; // Clear the link register
				ctrl.regWrite = 1'b1;
			end
			ctrlPkg::stFetch: begin
				ctrl.srcA = ctrlPkg::srcAPc;
				ctrl.srcB = ctrlPkg::srcBFour;
				ctrl.aluOp = ctrlPkg::aluAdd;
			end
			ctrlPkg::stFetchWait: ctrl.irWrite = 1'b1;
			ctrlPkg::stDecode: begin
				ctrl.irWrite = 1'b1;
				ctrl.aWrite = 1'b1;
				ctrl.bWrite = 1'b1;
				// Branch target computed ahead of time
				ctrl.srcA = ctrlPkg::srcAPc;
				ctrl.srcB = ctrlPkg::srcBImmShift;
				ctrl.aluOp = ctrlPkg::aluAdd;
				ctrl.aluOutWrite = 1'b1;
			end
			ctrlPkg::stArith1, ctrlPkg::stArith2, ctrlPkg::stImm1, ctrlPkg::stImm2: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				if (isRType) begin
					ctrl.srcB = ctrlPkg::srcBRegB;
				end else begin
					ctrl.srcB = ctrlPkg::srcBImm;
				end
				ctrl.aluOp = aluOp;
				ctrl.aluOutWrite = 1'b1;
			end
			ctrlPkg::stArith3, ctrlPkg::stImm3: begin
				if (isRType) begin
					ctrl.regDst = ctrlPkg::dstRd;
				end else begin
					ctrl.regDst = ctrlPkg::dstRt;
				end
				ctrl.wbSrc = ctrlPkg::wbAluOut;
				ctrl.regWrite = 1'b1;
			end
			ctrlPkg::stBranch1: begin
				ctrl.srcA = ctrlPkg::srcAPc;
				ctrl.srcB = ctrlPkg::srcBImmShift;
				ctrl.aluOp = ctrlPkg::aluAdd;
				ctrl.aluOutWrite = 1'b1;
			end
			ctrlPkg::stBranch2: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				ctrl.srcB = ctrlPkg::srcBRegB;
				ctrl.aluOp = aluOp;
				ctrl.pcSrc = ctrlPkg::pcAluOut; // Target held in ALUOut
				ctrl.branchOn = branchSense;
				ctrl.pcWriteCond = 1'b1;
			end
			ctrlPkg::stLoad1, ctrlPkg::stStore1: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				ctrl.srcB = ctrlPkg::srcBImm;
				ctrl.aluOp = aluOp;
				ctrl.aluOutWrite = 1'b1;
			end
			ctrlPkg::stLoad3: ctrl.mdrWrite = 1'b1;
			ctrlPkg::stLoad4: begin
				ctrl.regDst = ctrlPkg::dstRt;
				ctrl.wbSrc = ctrlPkg::wbMemData;
				ctrl.regWrite = 1'b1;
			end
			ctrlPkg::stStore3: ctrl.memWrite = 1'b1;
			ctrlPkg::stJal: begin
				ctrl.regDst = ctrlPkg::dstRa;
				ctrl.wbSrc = ctrlPkg::wbPc; // Return address
				ctrl.regWrite = 1'b1;
			end
			ctrlPkg::stJump: begin
				ctrl.pcSrc = ctrlPkg::pcJumpTarget;
				ctrl.pcWrite = 1'b1;
			end
			ctrlPkg::stJr: begin
				ctrl.pcSrc = ctrlPkg::pcRegA;
				ctrl.pcWrite = 1'b1;
			end
			ctrlPkg::stExc1: begin
				ctrl.pcSrc = excVector;
				ctrl.epcWrite = 1'b1; // Save faulting PC
			end
			ctrlPkg::stExc2, ctrlPkg::stExc3: begin
				ctrl.pcSrc = excVector;
				ctrl.pcWrite = 1'b1;
			end
			default: ctrl = ctrlPkg::ctrlIdle; // Idle, wait states and break
		endcase
	end

endmodule

// File: rtl/stateSequencer.sv
`timescale 1ns/10ps

module stateSequencer (
	input logic Clk,
	input logic Reset,
	input ctrlPkg::instrClassT instrClass,
	input logic isAddiu,
	input logic overflow,
	output ctrlPkg::stateT state,
	output logic excEnter,
	output ctrlPkg::excCauseT excCauseNext
);

	ctrlPkg::stateT nextState;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= ctrlPkg::stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		excEnter = 1'b0;
		excCauseNext = ctrlPkg::causeOverflow;
		case (state)
			ctrlPkg::stReset: nextState = ctrlPkg::stIdle;
			ctrlPkg::stIdle: nextState = ctrlPkg::stFetch;
			ctrlPkg::stFetch: nextState = ctrlPkg::stFetchWait;
			ctrlPkg::stFetchWait: nextState = ctrlPkg::stDecode;
			ctrlPkg::stDecode: begin
				case (instrClass)
					ctrlPkg::clsNop: nextState = ctrlPkg::stIdle;
					ctrlPkg::clsArith: nextState = ctrlPkg::stArith1;
					ctrlPkg::clsArithImm: nextState = ctrlPkg::stImm1;
					ctrlPkg::clsBranch: nextState = ctrlPkg::stBranch1;
					ctrlPkg::clsLoad: nextState = ctrlPkg::stLoad1;
					ctrlPkg::clsStore: nextState = ctrlPkg::stStore1;
					ctrlPkg::clsJump: nextState = ctrlPkg::stJump;
					ctrlPkg::clsJal: nextState = ctrlPkg::stJal;
					ctrlPkg::clsJr: nextState = ctrlPkg::stJr;
					ctrlPkg::clsBreak: nextState = ctrlPkg::stBreak;
					default: begin
						nextState = ctrlPkg::stExc1; // Unknown opcode or funct
						excEnter = 1'b1;
						excCauseNext = ctrlPkg::causeOpcode;
					end
				endcase
			end
			ctrlPkg::stArith1: nextState = ctrlPkg::stArith2;
			ctrlPkg::stArith2: begin
				if (overflow) begin
					nextState = ctrlPkg::stExc1; // Result never written back
					excEnter = 1'b1;
				end else begin
					nextState = ctrlPkg::stArith3;
				end
			end
			ctrlPkg::stArith3: nextState = ctrlPkg::stIdle;
			ctrlPkg::stImm1: nextState = ctrlPkg::stImm2;
			ctrlPkg::stImm2: begin
				if (overflow && !isAddiu) begin
					nextState = ctrlPkg::stExc1;
					excEnter = 1'b1;
				end else begin
					nextState = ctrlPkg::stImm3;
				end
			end
			ctrlPkg::stImm3: nextState = ctrlPkg::stIdle;
			ctrlPkg::stBranch1: nextState = ctrlPkg::stBranch2;
			ctrlPkg::stBranch2: nextState = ctrlPkg::stIdle;
			ctrlPkg::stLoad1: nextState = ctrlPkg::stLoad2;
			ctrlPkg::stLoad2: nextState = ctrlPkg::stLoad3;
			ctrlPkg::stLoad3: nextState = ctrlPkg::stLoad4;
			ctrlPkg::stLoad4: nextState = ctrlPkg::stIdle;
			ctrlPkg::stStore1: nextState = ctrlPkg::stStore2;
			ctrlPkg::stStore2: nextState = ctrlPkg::stStore3;
			ctrlPkg::stStore3: nextState = ctrlPkg::stIdle;
			ctrlPkg::stJal: nextState = ctrlPkg::stJump; // Link first, then jump
			ctrlPkg::stJump: nextState = ctrlPkg::stIdle;
			ctrlPkg::stJr: nextState = ctrlPkg::stIdle;
			ctrlPkg::stBreak: nextState = ctrlPkg::stBreak; // Halt until reset
			ctrlPkg::stExc1: nextState = ctrlPkg::stExc2;
			ctrlPkg::stExc2: nextState = ctrlPkg::stExc3;
			ctrlPkg::stExc3: nextState = ctrlPkg::stIdle;
			default: nextState = ctrlPkg::stIdle;
		endcase
	end

endmodule

// File: rtl/opDecoder.sv
`timescale 1ns/10ps

module opDecoder (
	input ctrlPkg::instrWordU instr,
	output ctrlPkg::instrClassT instrClass,
	output ctrlPkg::aluOpT aluOp,
	output logic isAddiu
);

	logic zeroFields;

	// sll with all operand fields zero is the canonical nop
	assign zeroFields = ({instr.rFields.rs, instr.rFields.rt,
		instr.rFields.rd, instr.rFields.shamt} == '0);

	always_comb begin
		instrClass = ctrlPkg::clsIllegal;
		aluOp = ctrlPkg::aluNone;
		isAddiu = 1'b0;
		case (instr.rFields.opcode)
			ctrlPkg::opRType: begin
				case (instr.rFields.funct)
					ctrlPkg::fnSll: begin
						if (zeroFields) begin
							instrClass = ctrlPkg::clsNop;
						end
					end
					ctrlPkg::fnJr: instrClass = ctrlPkg::clsJr;
					ctrlPkg::fnBreak: instrClass = ctrlPkg::clsBreak;
					ctrlPkg::fnAdd: begin
						instrClass = ctrlPkg::clsArith;
						aluOp = ctrlPkg::aluAdd;
					end
					ctrlPkg::fnSub: begin
						instrClass = ctrlPkg::clsArith;
						aluOp = ctrlPkg::aluSub;
					end
					ctrlPkg::fnAnd: begin
						instrClass = ctrlPkg::clsArith;
						aluOp = ctrlPkg::aluAnd;
					end
					default: instrClass = ctrlPkg::clsIllegal;
				endcase
			end
			ctrlPkg::opJ: instrClass = ctrlPkg::clsJump;
			ctrlPkg::opJal: instrClass = ctrlPkg::clsJal;
			ctrlPkg::opBeq, ctrlPkg::opBne: begin
				instrClass = ctrlPkg::clsBranch;
				aluOp = ctrlPkg::aluSub; // Compare by subtraction
			end
			ctrlPkg::opAddi: begin
				instrClass = ctrlPkg::clsArithImm;
				aluOp = ctrlPkg::aluAdd;
			end
			ctrlPkg::opAddiu: begin
				instrClass = ctrlPkg::clsArithImm;
				aluOp = ctrlPkg::aluAdd;
				isAddiu = 1'b1; // Overflow ignored
			end
			ctrlPkg::opLw: begin
				instrClass = ctrlPkg::clsLoad;
				aluOp = ctrlPkg::aluAdd; // Base plus offset
			end
			ctrlPkg::opSw: begin
				instrClass = ctrlPkg::clsStore;
				aluOp = ctrlPkg::aluAdd;
			end
			default: instrClass = ctrlPkg::clsIllegal;
		endcase
	end

endmodule

// File: rtl/instrRegister.sv
`timescale 1ns/10ps

module instrRegister (
	input logic Clk,
	input logic Reset,
	input ctrlPkg::stateT state,
	input logic [ctrlPkg::wordW-1:0] memData,
	input logic excEnter,
	input ctrlPkg::excCauseT excCauseNext,
	output ctrlPkg::instrWordU instr,
	output ctrlPkg::excCauseT cause
);

	logic loadInstr;

	// Memory word is valid at the end of the wait state
	assign loadInstr = (state == ctrlPkg::stFetchWait);

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			instr <= '0;
		end else if (loadInstr) begin
			instr <= ctrlPkg::instrWordU'(memData);
		end
	end

	// Cause stays valid through the whole exception sequence
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			cause <= ctrlPkg::causeOverflow;
		end else if (excEnter) begin
			cause <= excCauseNext;
		end
	end

endmodule

// File: rtl/ctrlPkg.sv
package ctrlPkg;

	localparam int wordW = 32;
	localparam int opW = 6;

	localparam logic [opW-1:0] opRType = 6'd0;
	localparam logic [opW-1:0] opJ = 6'd2;
	localparam logic [opW-1:0] opJal = 6'd3;
	localparam logic [opW-1:0] opBeq = 6'd4;
	localparam logic [opW-1:0] opBne = 6'd5;
	localparam logic [opW-1:0] opAddi = 6'd8;
	localparam logic [opW-1:0] opAddiu = 6'd9;
	localparam logic [opW-1:0] opLw = 6'd35;
	localparam logic [opW-1:0] opSw = 6'd43;

	localparam logic [opW-1:0] fnSll = 6'd0; // Also the nop encoding
	localparam logic [opW-1:0] fnJr = 6'd8;
	localparam logic [opW-1:0] fnBreak = 6'd13;
	localparam logic [opW-1:0] fnAdd = 6'd32;
	localparam logic [opW-1:0] fnSub = 6'd34;
	localparam logic [opW-1:0] fnAnd = 6'd36;

	typedef enum logic [2:0] {aluNone, aluAdd, aluSub, aluAnd} aluOpT;

	typedef enum logic [1:0] {srcAPc, srcARegA} srcAT;
	typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBImmShift} srcBT;
	typedef enum logic [2:0] {
		pcAluResult, pcAluOut, pcJumpTarget, pcRegA, pcOvfVector, pcOpcVector
	} pcSrcT;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
	typedef enum logic [1:0] {wbAluOut, wbMemData, wbPc} wbSrcT;
	typedef enum logic {brOnZero, brOnNotZero} branchT;

	typedef enum logic [3:0] {
		clsNop, clsArith, clsArithImm, clsBranch, clsLoad, clsStore,
		clsJump, clsJal, clsJr, clsBreak, clsIllegal
	} instrClassT;

	typedef enum logic [4:0] {
		stReset, stIdle, stFetch, stFetchWait, stDecode,
		stArith1, stArith2, stArith3,
		stImm1, stImm2, stImm3,
		stBranch1, stBranch2,
		stLoad1, stLoad2, stLoad3, stLoad4,
		stStore1, stStore2, stStore3,
		stJal, stJump, stJr, stBreak,
		stExc1, stExc2, stExc3
	} stateT;

	// R-type and I-type views of one instruction word
	typedef union packed {
		struct packed {
			logic [opW-1:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [opW-1:0] funct;
		} rFields;
		struct packed {
			logic [opW-1:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iFields;
	} instrWordU;

	typedef struct packed {
		srcAT srcA;
		srcBT srcB;
		aluOpT aluOp;
		pcSrcT pcSrc;
		regDstT regDst;
		wbSrcT wbSrc;
		branchT branchOn;
		logic pcWrite;
		logic pcWriteCond;
		logic irWrite;
		logic aWrite;
		logic bWrite;
		logic aluOutWrite;
		logic mdrWrite;
		logic epcWrite;
		logic regWrite;
		logic memWrite;
	} ctrlWordT;

	localparam ctrlWordT ctrlIdle = '0; // No strobes, every select at its first value

	typedef enum logic {causeOverflow, causeOpcode} excCauseT;

endpackage
